// File: design/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

//////////////////////////////
// Core widths

`define RV_XLEN 32
`define RV_NUM_REGS 32

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

//////////////////////////////
// Major opcodes, instr[6:0]

`define RV_OPC_LUI 7'b0110111
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP 7'b0110011
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_JAL 7'b1101111

`endif

// File: design/rv_core_pkg.sv
`include "rv_core_cfg.svh"

package rv_core_pkg;

    //////////////////////////////
    // Vector types

    // Data value or byte address
    typedef logic [`RV_XLEN-1:0] word_t;

    // Raw instruction word from memory
    typedef logic [31:0] instr_t;

    // Architectural register index
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

    // ALU operation selector
    typedef logic [3:0] alu_op_t;

    // Branch condition, same encoding as funct3
    typedef logic [2:0] br_cond_t;

    //////////////////////////////
    // ALU operations

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_SLL = 4'd2;
    localparam alu_op_t ALU_SLT = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR = 4'd5;
    localparam alu_op_t ALU_SRL = 4'd6;
    localparam alu_op_t ALU_SRA = 4'd7;
    localparam alu_op_t ALU_OR = 4'd8;
    localparam alu_op_t ALU_AND = 4'd9;

    // Operand b straight through, used by LUI
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // Return address, operand a plus 4, used by JAL
    localparam alu_op_t ALU_LINK = 4'd11;

endpackage

// File: design/fetch_stage.sv
`include "rv_core_cfg.svh"

module fetch_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               redirect,
    input  rv_core_pkg::word_t redirect_pc,
    output logic               imem_req,
    output rv_core_pkg::word_t imem_addr,
    output logic               fd_valid,
    output rv_core_pkg::word_t fd_pc
);
    import rv_core_pkg::*;

    word_t pc;
    word_t pc_next;

    //////////////////////////////
    // Next PC

    // Redirect from execute wins over the sequential step
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (imem_req) begin
            pc_next = pc + word_t'(4);
        end else begin
            // First cycle after reset, address not yet requested
            pc_next = pc;
        end
    end

    //////////////////////////////
    // PC and request strobe

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
            imem_req <= 1'b0;
            fd_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            imem_req <= 1'b1;
            // Memory answers one cycle after the request
            fd_valid <= imem_req;
        end
    end

    // Address of the word coming back from memory next cycle
    always_ff @(posedge clk) begin
        fd_pc <= pc;
    end

    assign imem_addr = pc;

endmodule

// File: design/decode_stage.sv
`include "rv_core_cfg.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fd_valid,
    input  rv_core_pkg::word_t      fd_pc,
    input  rv_core_pkg::instr_t     imem_rdata,
    input  logic                    redirect,
    input  rv_core_pkg::word_t      rf_rs1_val,
    input  rv_core_pkg::word_t      rf_rs2_val,
    input  rv_core_pkg::reg_addr_t  fwd_rd,
    input  logic                    fwd_we,
    input  rv_core_pkg::word_t      fwd_value,
    output rv_core_pkg::reg_addr_t  rf_rs1,
    output rv_core_pkg::reg_addr_t  rf_rs2,
    output logic                    de_valid,
    output rv_core_pkg::word_t      de_pc,
    output rv_core_pkg::alu_op_t    de_op,
    output rv_core_pkg::word_t      de_a,
    output rv_core_pkg::word_t      de_b,
    output logic                    de_is_branch,
    output logic                    de_is_jal,
    output rv_core_pkg::br_cond_t   de_cond,
    output rv_core_pkg::word_t      de_rs1_val,
    output rv_core_pkg::word_t      de_rs2_val,
    output rv_core_pkg::word_t      de_imm,
    output rv_core_pkg::reg_addr_t  de_rd,
    output logic                    de_we
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm_i;
    word_t imm_u;
    word_t imm_b;
    word_t imm_j;
    word_t rs1_val;
    word_t rs2_val;
    word_t a_sel;
    word_t b_sel;
    word_t imm_sel;
    alu_op_t op;
    logic is_branch;
    logic is_jal;
    logic writes_rd;
    logic squash_next;

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic alu_op_t alu_op_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? ALU_SUB : ALU_ADD;
            3'b001: return ALU_SLL;
            3'b010: return ALU_SLT;
            3'b011: return ALU_SLTU;
            3'b100: return ALU_XOR;
            3'b101: return alt ? ALU_SRA : ALU_SRL;
            3'b110: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Younger result in execute beats the register file
    function automatic word_t operand(input reg_addr_t src, input word_t rf_val);
        if (src != '0 && fwd_we && fwd_rd == src) begin
            return fwd_value;
        end
        return rf_val;
    endfunction

    //////////////////////////////
    // Fields and immediates

    assign opcode = imem_rdata[6:0];
    assign funct3 = imem_rdata[14:12];
    assign funct7 = imem_rdata[31:25];
    assign rf_rs1 = imem_rdata[19:15];
    assign rf_rs2 = imem_rdata[24:20];

    assign imm_i = {{20{imem_rdata[31]}}, imem_rdata[31:20]};
    assign imm_u = {imem_rdata[31:12], 12'b0};
    assign imm_b = {{19{imem_rdata[31]}}, imem_rdata[31], imem_rdata[7],
                    imem_rdata[30:25], imem_rdata[11:8], 1'b0};
    assign imm_j = {{11{imem_rdata[31]}}, imem_rdata[31], imem_rdata[19:12],
                    imem_rdata[20], imem_rdata[30:21], 1'b0};

    always_comb begin
        rs1_val = operand(rf_rs1, rf_rs1_val);
        rs2_val = operand(rf_rs2, rf_rs2_val);
    end

    //////////////////////////////
    // Opcode decode

    always_comb begin
        op = ALU_ADD;
        a_sel = rs1_val;
        b_sel = rs2_val;
        imm_sel = imm_i;
        is_branch = 1'b0;
        is_jal = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            `RV_OPC_LUI: begin
                op = ALU_PASS_B;
                b_sel = imm_u;
                imm_sel = imm_u;
                writes_rd = 1'b1;
            end
            `RV_OPC_OP_IMM: begin
                // Only the right shift reads bit 30 as a modifier
                op = alu_op_of(funct3, funct3 == 3'b101 && funct7[5]);
                b_sel = imm_i;
                case (funct3)
                    3'b001: writes_rd = (funct7 == 7'b0000000);
                    3'b101: writes_rd = (funct7 == 7'b0000000 || funct7 == 7'b0100000);
                    default: writes_rd = 1'b1;
                endcase
            end
            `RV_OPC_OP: begin
                op = alu_op_of(funct3, funct7[5]);
                writes_rd = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `RV_OPC_BRANCH: begin
                imm_sel = imm_b;
                is_branch = (funct3 != 3'b010 && funct3 != 3'b011);
            end
            `RV_OPC_JAL: begin
                op = ALU_LINK;
                a_sel = fd_pc;
                imm_sel = imm_j;
                is_jal = 1'b1;
                writes_rd = 1'b1;
            end
            default: begin
                // Unsupported, retires as a no-op
            end
        endcase
    end

    //////////////////////////////
    // Decode to execute register

    // Two slots behind a redirect are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            squash_next <= 1'b0;
            de_valid <= 1'b0;
            de_is_branch <= 1'b0;
            de_is_jal <= 1'b0;
            de_we <= 1'b0;
        end else begin
            squash_next <= redirect;
            de_valid <= fd_valid && !redirect && !squash_next;
            de_is_branch <= is_branch;
            de_is_jal <= is_jal;
            de_we <= writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        de_pc <= fd_pc;
        de_op <= op;
        de_a <= a_sel;
        de_b <= b_sel;
        de_cond <= funct3;
        de_rs1_val <= rs1_val;
        de_rs2_val <= rs2_val;
        de_imm <= imm_sel;
        de_rd <= imem_rdata[11:7];
    end

endmodule

// File: design/register_file.sv
`include "rv_core_cfg.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    input  logic                   we,
    input  rv_core_pkg::reg_addr_t rd,
    input  rv_core_pkg::word_t     wd,
    output rv_core_pkg::word_t     rs1_val,
    output rv_core_pkg::word_t     rs2_val
);
    import rv_core_pkg::*;

    // Entry 0 is never written and stays zero
    word_t regs [`RV_NUM_REGS];

    // Write-through so decode sees the value landing this edge
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we && rd == addr) begin
            return wd;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    always_comb begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

endmodule

// File: design/execute_stage.sv
module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   de_valid,
    input  rv_core_pkg::word_t     de_pc,
    input  rv_core_pkg::alu_op_t   de_op,
    input  rv_core_pkg::word_t     de_a,
    input  rv_core_pkg::word_t     de_b,
    input  logic                   de_is_branch,
    input  logic                   de_is_jal,
    input  rv_core_pkg::br_cond_t  de_cond,
    input  rv_core_pkg::word_t     de_rs1_val,
    input  rv_core_pkg::word_t     de_rs2_val,
    input  rv_core_pkg::word_t     de_imm,
    input  rv_core_pkg::reg_addr_t de_rd,
    input  logic                   de_we,
    output logic                   redirect,
    output rv_core_pkg::word_t     redirect_pc,
    output rv_core_pkg::reg_addr_t fwd_rd,
    output logic                   fwd_we,
    output rv_core_pkg::word_t     fwd_value,
    output logic                   wb_valid,
    output rv_core_pkg::word_t     wb_pc,
    output rv_core_pkg::reg_addr_t wb_rd,
    output logic                   wb_we,
    output rv_core_pkg::word_t     wb_value
);
    import rv_core_pkg::*;

    word_t alu_result;
    logic taken;

    //////////////////////////////
    // ALU

    always_comb begin
        case (de_op)
            ALU_ADD: alu_result = de_a + de_b;
            ALU_SUB: alu_result = de_a - de_b;
            ALU_SLL: alu_result = de_a << de_b[4:0];
            ALU_SLT: alu_result = word_t'($signed(de_a) < $signed(de_b));
            ALU_SLTU: alu_result = word_t'(de_a < de_b);
            ALU_XOR: alu_result = de_a ^ de_b;
            ALU_SRL: alu_result = de_a >> de_b[4:0];
            ALU_SRA: alu_result = word_t'($signed(de_a) >>> de_b[4:0]);
            ALU_OR: alu_result = de_a | de_b;
            ALU_AND: alu_result = de_a & de_b;
            ALU_PASS_B: alu_result = de_b;
            ALU_LINK: alu_result = de_a + word_t'(4);
            default: alu_result = '0;
        endcase
    end

    //////////////////////////////
    // Branch unit

    // Condition codes follow funct3 of the branch
    always_comb begin
        case (de_cond)
            3'b000: taken = (de_rs1_val == de_rs2_val);
            3'b001: taken = (de_rs1_val != de_rs2_val);
            3'b100: taken = ($signed(de_rs1_val) < $signed(de_rs2_val));
            3'b101: taken = ($signed(de_rs1_val) >= $signed(de_rs2_val));
            3'b110: taken = (de_rs1_val < de_rs2_val);
            3'b111: taken = (de_rs1_val >= de_rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = de_valid && (de_is_jal || (de_is_branch && taken));
    assign redirect_pc = de_pc + de_imm;

    // Result visible to decode in the same cycle
    assign fwd_rd = de_rd;
    assign fwd_we = de_valid && de_we && (de_rd != '0);
    assign fwd_value = alu_result;

    //////////////////////////////
    // Retire registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_we <= 1'b0;
        end else begin
            wb_valid <= de_valid;
            wb_we <= fwd_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc <= de_pc;
        wb_rd <= de_rd;
        wb_value <= alu_result;
    end

endmodule

// File: design/rv_core.sv
module rv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::instr_t    imem_rdata,
    output logic                   imem_req,
    output rv_core_pkg::word_t     imem_addr,
    output logic                   retire_valid,
    output rv_core_pkg::word_t     retire_pc,
    output rv_core_pkg::reg_addr_t retire_rd,
    output logic                   retire_we,
    output rv_core_pkg::word_t     retire_value
);
    import rv_core_pkg::*;

    // Fetch to decode
    logic fd_valid;
    word_t fd_pc;

    // Register file read side
    reg_addr_t rf_rs1;
    reg_addr_t rf_rs2;
    word_t rf_rs1_val;
    word_t rf_rs2_val;

    // Decode to execute
    logic de_valid;
    word_t de_pc;
    alu_op_t de_op;
    word_t de_a;
    word_t de_b;
    logic de_is_branch;
    logic de_is_jal;
    br_cond_t de_cond;
    word_t de_rs1_val;
    word_t de_rs2_val;
    word_t de_imm;
    reg_addr_t de_rd;
    logic de_we;

    // Execute feedback
    logic redirect;
    word_t redirect_pc;
    reg_addr_t fwd_rd;
    logic fwd_we;
    word_t fwd_value;

    //////////////////////////////
    // Fetch

    fetch_stage fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .fd_valid    (fd_valid),
        .fd_pc       (fd_pc)
    );

    //////////////////////////////
    // Decode and register file

    decode_stage decode_i (
        .clk (clk), .rst_n (rst_n),
        .fd_valid (fd_valid), .fd_pc (fd_pc), .imem_rdata (imem_rdata), .redirect (redirect),
        .rf_rs1_val (rf_rs1_val), .rf_rs2_val (rf_rs2_val),
        .fwd_rd (fwd_rd), .fwd_we (fwd_we), .fwd_value (fwd_value),
        .rf_rs1 (rf_rs1), .rf_rs2 (rf_rs2),
        .de_valid (de_valid), .de_pc (de_pc), .de_op (de_op), .de_a (de_a), .de_b (de_b),
        .de_is_branch (de_is_branch), .de_is_jal (de_is_jal), .de_cond (de_cond),
        .de_rs1_val (de_rs1_val), .de_rs2_val (de_rs2_val), .de_imm (de_imm),
        .de_rd (de_rd), .de_we (de_we)
    );

    // Written from the retire registers
    register_file regfile_i (
        .clk (clk), .rst_n (rst_n),
        .rs1 (rf_rs1), .rs2 (rf_rs2),
        .we (retire_we), .rd (retire_rd), .wd (retire_value),
        .rs1_val (rf_rs1_val), .rs2_val (rf_rs2_val)
    );

    //////////////////////////////
    // Execute and writeback

    execute_stage execute_i (
        .clk (clk), .rst_n (rst_n),
        .de_valid (de_valid), .de_pc (de_pc), .de_op (de_op), .de_a (de_a), .de_b (de_b),
        .de_is_branch (de_is_branch), .de_is_jal (de_is_jal), .de_cond (de_cond),
        .de_rs1_val (de_rs1_val), .de_rs2_val (de_rs2_val), .de_imm (de_imm),
        .de_rd (de_rd), .de_we (de_we),
        .redirect (redirect), .redirect_pc (redirect_pc),
        .fwd_rd (fwd_rd), .fwd_we (fwd_we), .fwd_value (fwd_value),
        .wb_valid (retire_valid), .wb_pc (retire_pc), .wb_rd (retire_rd),
        .wb_we (retire_we), .wb_value (retire_value)
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // Free-running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

// File: bench/rv_core_tb.sv
module rv_core_tb;
    import rv_core_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 8;
    localparam int RETIRE_TIMEOUT = 16;
    localparam int PROG_WORDS = 256;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam instr_t NOP = 32'h0000_0013;

    logic clk;
    logic rst_n = 1'b0;
    instr_t imem_rdata = NOP;
    logic imem_req;
    word_t imem_addr;
    logic retire_valid;
    word_t retire_pc;
    reg_addr_t retire_rd;
    logic retire_we;
    word_t retire_value;

    // Program and expected retire record, one entry per word address
    instr_t prog_instr [PROG_WORDS];
    logic exp_retires [PROG_WORDS];
    word_t exp_pc [PROG_WORDS];
    reg_addr_t exp_rd [PROG_WORDS];
    logic exp_we [PROG_WORDS];
    word_t exp_value [PROG_WORDS];
    string exp_name [PROG_WORDS];
    int prog_len = 0;

    logic mem_req_q = 1'b0;
    word_t mem_addr_q = '0;

    tb_clock #(.PERIOD(CLK_PERIOD)) clock_i (.clk(clk));

    rv_core rv_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_value (retire_value)
    );

    //////////////////////////////
    // Instruction encoders

    function automatic instr_t r_type(input int f7, input int rs2, input int rs1, input int f3,
                                      input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic instr_t i_type(input logic [6:0] opc, input int imm, input int rs1,
                                      input int f3, input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic instr_t b_type(input int off, input int rs2, input int rs1, input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t u_type(input int imm, input int rd);
        return {imm[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic instr_t j_type(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    //////////////////////////////
    // Memory model

    // Unused words get a pattern of their own address
    function automatic instr_t fetch_word(input word_t addr);
        if (addr < word_t'(prog_len * 4)) begin
            return prog_instr[addr[9:2]];
        end
        return addr ^ 32'h3c5a_96e1;
    endfunction

    // Data for the previous edge's request, one cycle latency
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (mem_req_q) begin
            imem_rdata = fetch_word(mem_addr_q);
        end
        mem_req_q = imem_req;
        mem_addr_q = imem_addr;
    end

    //////////////////////////////
    // Program table

    task automatic table_entry(input string name, input instr_t instr, input logic retires,
                               input logic we, input int rd, input word_t value);
        prog_instr[prog_len] = instr;
        exp_retires[prog_len] = retires;
        exp_pc[prog_len] = word_t'(prog_len * 4);
        exp_rd[prog_len] = rd[4:0];
        exp_we[prog_len] = we;
        exp_value[prog_len] = value;
        exp_name[prog_len] = name;
        prog_len++;
    endtask

    task automatic expect_write(input string name, input instr_t instr, input int rd,
                                input word_t value);
        table_entry(name, instr, 1'b1, rd != 0, rd, value);
    endtask

    task automatic expect_no_write(input string name, input instr_t instr);
        table_entry(name, instr, 1'b1, 1'b0, 0, '0);
    endtask

    // Target is PC+16, so two slots are squashed and one word is never fetched
    task automatic expect_redirect(input string name, input instr_t instr, input int rd,
                                   input word_t value);
        table_entry(name, instr, 1'b1, rd != 0, rd, value);
        table_entry("squashed", i_type(OPC_OP_IMM, -1, 0, 0, 31), 1'b0, 1'b0, 0, '0);
        table_entry("squashed", i_type(OPC_OP_IMM, -1, 0, 0, 31), 1'b0, 1'b0, 0, '0);
        table_entry("skipped", i_type(OPC_OP_IMM, -1, 0, 0, 31), 1'b0, 1'b0, 0, '0);
    endtask

    task automatic build_program();
        word_t acc;
        logic [31:0] lcg_state;
        int imm;
        int rs1;
        // Operands x1 = f0f0f0f5, x2 = 7, x3 = -3
        expect_write("lui", u_type('hf0f0f, 1), 1, 32'hf0f0_f000);
        expect_write("addi fwd", i_type(OPC_OP_IMM, 'h0f5, 1, 0, 1), 1, 32'hf0f0_f0f5);
        expect_write("addi pos", i_type(OPC_OP_IMM, 7, 0, 0, 2), 2, 32'h0000_0007);
        expect_write("addi neg", i_type(OPC_OP_IMM, -3, 0, 0, 3), 3, 32'hffff_fffd);
        expect_write("add", r_type(0, 2, 1, 0, 4), 4, 32'hf0f0_f0fc);
        expect_write("sub", r_type('h20, 2, 1, 0, 5), 5, 32'hf0f0_f0ee);
        expect_write("sll", r_type(0, 2, 1, 1, 6), 6, 32'h7878_7a80);
        expect_write("slt", r_type(0, 2, 1, 2, 7), 7, 32'h0000_0001);
        expect_write("sltu", r_type(0, 2, 1, 3, 8), 8, 32'h0000_0000);
        expect_write("xor", r_type(0, 2, 1, 4, 9), 9, 32'hf0f0_f0f2);
        expect_write("srl", r_type(0, 2, 1, 5, 10), 10, 32'h01e1_e1e1);
        expect_write("sra", r_type('h20, 2, 1, 5, 11), 11, 32'hffe1_e1e1);
        expect_write("or", r_type(0, 2, 1, 6, 12), 12, 32'hf0f0_f0f7);
        expect_write("and", r_type(0, 2, 1, 7, 13), 13, 32'h0000_0005);
        expect_write("slt false", r_type(0, 3, 2, 2, 14), 14, 32'h0000_0000);
        expect_write("sltu true", r_type(0, 3, 2, 3, 15), 15, 32'h0000_0001);
        expect_write("addi", i_type(OPC_OP_IMM, -5, 1, 0, 16), 16, 32'hf0f0_f0f0);
        expect_write("slti", i_type(OPC_OP_IMM, -2, 3, 2, 17), 17, 32'h0000_0001);
        expect_write("sltiu", i_type(OPC_OP_IMM, -1, 2, 3, 18), 18, 32'h0000_0001);
        expect_write("xori", i_type(OPC_OP_IMM, 'h0ff, 1, 4, 19), 19, 32'hf0f0_f00a);
        expect_write("ori", i_type(OPC_OP_IMM, 'h700, 2, 6, 20), 20, 32'h0000_0707);
        expect_write("andi", i_type(OPC_OP_IMM, -16, 1, 7, 21), 21, 32'hf0f0_f0f0);
        expect_write("slli", i_type(OPC_OP_IMM, 28, 2, 1, 22), 22, 32'h7000_0000);
        expect_write("srli", i_type(OPC_OP_IMM, 4, 1, 5, 23), 23, 32'h0f0f_0f0f);
        expect_write("srai", i_type(OPC_OP_IMM, 'h404, 1, 5, 24), 24, 32'hff0f_0f0f);

        // Distance 1 hits execute forwarding, distance 2 the write-through
        expect_write("hazard base", i_type(OPC_OP_IMM, 100, 0, 0, 25), 25, 32'd100);
        expect_write("hazard fwd", r_type(0, 25, 25, 0, 26), 26, 32'd200);
        expect_write("hazard bypass", r_type('h20, 25, 26, 0, 27), 27, 32'd100);
        expect_write("hazard mixed", r_type(0, 26, 25, 4, 28), 28, 32'h0000_00ac);

        expect_no_write("write x0", i_type(OPC_OP_IMM, 5, 2, 0, 0));
        expect_no_write("load", i_type(OPC_LOAD, 0, 2, 2, 5));
        expect_no_write("zero word", 32'h0000_0000);
        expect_write("read x0", r_type(0, 2, 0, 0, 29), 29, 32'h0000_0007);

        expect_no_write("beq not taken", b_type(12, 2, 1, 0));
        expect_no_write("blt not taken", b_type(12, 3, 2, 4));
        expect_no_write("bgeu not taken", b_type(12, 3, 2, 7));
        expect_no_write("bne not taken", b_type(12, 27, 25, 1));

        expect_redirect("beq taken", b_type(16, 27, 25, 0), 0, '0);
        expect_redirect("bne taken", b_type(16, 2, 1, 1), 0, '0);
        expect_redirect("blt taken", b_type(16, 2, 3, 4), 0, '0);
        expect_redirect("bge taken", b_type(16, 3, 2, 5), 0, '0);
        expect_redirect("bltu taken", b_type(16, 3, 2, 6), 0, '0);
        expect_redirect("bgeu taken", b_type(16, 2, 3, 7), 0, '0);
        expect_redirect("jal link", j_type(16, 30), 30, word_t'(prog_len * 4 + 4));

        // ADDI and XORI chain on x31
        lcg_state = 32'd87783;
        acc = '0;
        for (int k = 0; k < 12; k++) begin
            lcg_state = lcg_next(lcg_state);
            imm = int'(lcg_state[27:16]);
            rs1 = (k == 0) ? 0 : 31;
            if (k % 2 == 0) begin
                acc = acc + sext12(imm[11:0]);
                expect_write($sformatf("lcg addi %0d", k), i_type(OPC_OP_IMM, imm, rs1, 0, 31),
                             31, acc);
            end else begin
                acc = acc ^ sext12(imm[11:0]);
                expect_write($sformatf("lcg xori %0d", k), i_type(OPC_OP_IMM, imm, rs1, 4, 31),
                             31, acc);
            end
        end

        expect_no_write("jal self", j_type(0, 0));
    endtask

    //////////////////////////////
    // Checks

    task automatic stop_on_error();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("Fail %s: expected x%0d, actual x%0d", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    // Sampled at the falling edge, well clear of the retire registers
    task automatic wait_retire(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire_valid && cycles < RETIRE_TIMEOUT);
        if (!retire_valid) begin
            $display("No instruction retired within %0d cycles, waiting for %s",
                     RETIRE_TIMEOUT, name);
            stop_on_error();
        end
    endtask

    initial begin
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        // Nothing requested or retired while in reset
        check_bit("reset imem_req", 1'b0, imem_req);
        check_bit("reset retire_valid", 1'b0, retire_valid);
        rst_n = 1'b1;

        for (int i = 0; i < prog_len; i++) begin
            if (exp_retires[i]) begin
                wait_retire(exp_name[i]);
                check_bit($sformatf("%s imem_req", exp_name[i]), 1'b1, imem_req);
                check_word($sformatf("%s pc", exp_name[i]), exp_pc[i], retire_pc);
                check_bit($sformatf("%s we", exp_name[i]), exp_we[i], retire_we);
                if (exp_we[i]) begin
                    check_reg($sformatf("%s rd", exp_name[i]), exp_rd[i], retire_rd);
                    check_word($sformatf("%s value", exp_name[i]), exp_value[i], retire_value);
                end
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// File: rv_core.f
+incdir+design
design/rv_core_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/rv_core.sv
bench/tb_clock.sv
bench/rv_core_tb.sv

// File: Makefile
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Regression passed

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
